// ==== Bender.yml ====
package:
  name: lce_cmd

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/lce_pkg.sv
      - rtl/lce_beat_tracker.sv
      - rtl/lce_sync_counter.sv
      - rtl/lce_cmd_fsm.sv
      - rtl/lce_cmd.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/tb_lce_cmd.sv

// ==== rtl/lce_beat_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lce_cfg.svh"

module lce_beat_tracker
  import lce_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      cmd_v_i,
  input  logic      cmd_ready_and_i,
  input  cmd_type_e cmd_type_i,
  output beat_t     beat_idx_o,
  output logic      first_o,
  output logic      last_o
);

  beat_t beat_r;
  logic  xfer;
  logic  is_data;

  assign xfer    = cmd_v_i & cmd_ready_and_i;
  assign is_data = (cmd_type_i == e_cmd_data);

  assign beat_idx_o = beat_r;
  assign first_o    = (beat_r == '0);
  // single-beat commands finish on beat zero
  assign last_o     = is_data ? (beat_r == beat_t'(`LCE_BEATS-1)) : (beat_r == '0);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      beat_r <= '0;
    end else if (xfer) begin
      beat_r <= last_o ? '0 : beat_r + 1'b1;
    end
  end

  // a single-beat command always finds the index back at zero
  beat_in_range_a: assert property (@(posedge clk_i) disable iff (reset_i)
    (cmd_v_i && !is_data) |-> (beat_r == '0));

endmodule

`default_nettype wire

// ==== rtl/lce_cfg.svh ====
`ifndef LCE_CFG_SVH
`define LCE_CFG_SVH

// cache geometry
`define LCE_SETS      8
`define LCE_ASSOC     2
`define LCE_PADDR_W   32
`define LCE_FILL_W    64
`define LCE_BLOCK_W   256
`define LCE_BEATS     4

// address split: tag | index | block offset
`define LCE_OFFSET_W  5
`define LCE_INDEX_W   3
`define LCE_CTAG_W    24

// coherence system
`define LCE_ID_W      4
`define LCE_NUM_CCE   2
`define LCE_CNT_W     4

`endif

// ==== rtl/lce_cmd.sv ====
`timescale 1ns/1ps
`default_nettype none

module lce_cmd
  import lce_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  lce_id_t    lce_id_i,
  input  logic       backoff_i,
  input  logic       cmd_v_i,
  input  cmd_type_e  cmd_type_i,
  input  paddr_t     cmd_addr_i,
  input  lce_id_t    cmd_src_i,
  input  way_t       cmd_way_i,
  input  coh_state_e cmd_state_i,
  input  fill_t      cmd_data_i,
  output logic       cmd_ready_and_o,
  output logic       tag_pkt_v_o,
  output tag_op_e    tag_pkt_op_o,
  output index_t     tag_pkt_index_o,
  output way_t       tag_pkt_way_o,
  output coh_state_e tag_pkt_state_o,
  output ctag_t      tag_pkt_tag_o,
  input  logic       tag_pkt_yumi_i,
  output logic       stat_pkt_v_o,
  output stat_op_e   stat_pkt_op_o,
  output index_t     stat_pkt_index_o,
  input  logic       stat_pkt_yumi_i,
  output logic       data_pkt_v_o,
  output data_op_e   data_pkt_op_o,
  output index_t     data_pkt_index_o,
  output way_t       data_pkt_way_o,
  output beat_t      data_pkt_beat_o,
  output fill_t      data_pkt_data_o,
  input  logic       data_pkt_yumi_i,
  output logic       resp_v_o,
  output resp_type_e resp_type_o,
  output paddr_t     resp_addr_o,
  output lce_id_t    resp_dst_o,
  output lce_id_t    resp_src_o,
  input  logic       resp_ready_and_i,
  output logic       cache_init_done_o,
  output logic       sync_done_o,
  output paddr_t     cache_req_addr_o,
  output logic       cache_req_critical_o,
  output logic       cache_req_last_o,
  output logic       cache_req_done_o,
  output logic       credit_return_o
);

  beat_t beat_idx;
  logic  first;
  logic  last;
  cnt_t  cnt;
  logic  cnt_inc;
  logic  cnt_clear;

  lce_beat_tracker u_beat_tracker (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .cmd_v_i         (cmd_v_i),
    .cmd_ready_and_i (cmd_ready_and_o),
    .cmd_type_i      (cmd_type_i),
    .beat_idx_o      (beat_idx),
    .first_o         (first),
    .last_o          (last)
  );

  // init sweep index and sync ack count share this counter
  lce_sync_counter u_sync_counter (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .cnt_inc_i   (cnt_inc),
    .cnt_clear_i (cnt_clear),
    .cnt_o       (cnt),
    .sync_done_o (sync_done_o)
  );

  lce_cmd_fsm u_cmd_fsm (
    .clk_i                (clk_i),
    .reset_i              (reset_i),
    .lce_id_i             (lce_id_i),
    .backoff_i            (backoff_i),
    .cmd_v_i              (cmd_v_i),
    .cmd_type_i           (cmd_type_i),
    .cmd_addr_i           (cmd_addr_i),
    .cmd_src_i            (cmd_src_i),
    .cmd_way_i            (cmd_way_i),
    .cmd_state_i          (cmd_state_i),
    .cmd_data_i           (cmd_data_i),
    .cmd_ready_and_o      (cmd_ready_and_o),
    .beat_idx_i           (beat_idx),
    .first_i              (first),
    .last_i               (last),
    .cnt_i                (cnt),
    .cnt_inc_o            (cnt_inc),
    .cnt_clear_o          (cnt_clear),
    .tag_pkt_v_o          (tag_pkt_v_o),
    .tag_pkt_op_o         (tag_pkt_op_o),
    .tag_pkt_index_o      (tag_pkt_index_o),
    .tag_pkt_way_o        (tag_pkt_way_o),
    .tag_pkt_state_o      (tag_pkt_state_o),
    .tag_pkt_tag_o        (tag_pkt_tag_o),
    .tag_pkt_yumi_i       (tag_pkt_yumi_i),
    .stat_pkt_v_o         (stat_pkt_v_o),
    .stat_pkt_op_o        (stat_pkt_op_o),
    .stat_pkt_index_o     (stat_pkt_index_o),
    .stat_pkt_yumi_i      (stat_pkt_yumi_i),
    .data_pkt_v_o         (data_pkt_v_o),
    .data_pkt_op_o        (data_pkt_op_o),
    .data_pkt_index_o     (data_pkt_index_o),
    .data_pkt_way_o       (data_pkt_way_o),
    .data_pkt_beat_o      (data_pkt_beat_o),
    .data_pkt_data_o      (data_pkt_data_o),
    .data_pkt_yumi_i      (data_pkt_yumi_i),
    .resp_v_o             (resp_v_o),
    .resp_type_o          (resp_type_o),
    .resp_addr_o          (resp_addr_o),
    .resp_dst_o           (resp_dst_o),
    .resp_src_o           (resp_src_o),
    .resp_ready_and_i     (resp_ready_and_i),
    .cache_init_done_o    (cache_init_done_o),
    .cache_req_addr_o     (cache_req_addr_o),
    .cache_req_critical_o (cache_req_critical_o),
    .cache_req_last_o     (cache_req_last_o),
    .cache_req_done_o     (cache_req_done_o),
    .credit_return_o      (credit_return_o)
  );

endmodule

`default_nettype wire

// ==== rtl/lce_cmd_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lce_cfg.svh"

module lce_cmd_fsm
  import lce_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  lce_id_t    lce_id_i,
  input  logic       backoff_i,
  input  logic       cmd_v_i,
  input  cmd_type_e  cmd_type_i,
  input  paddr_t     cmd_addr_i,
  input  lce_id_t    cmd_src_i,
  input  way_t       cmd_way_i,
  input  coh_state_e cmd_state_i,
  input  fill_t      cmd_data_i,
  output logic       cmd_ready_and_o,
  input  beat_t      beat_idx_i,
  input  logic       first_i,
  input  logic       last_i,
  input  cnt_t       cnt_i,
  output logic       cnt_inc_o,
  output logic       cnt_clear_o,
  output logic       tag_pkt_v_o,
  output tag_op_e    tag_pkt_op_o,
  output index_t     tag_pkt_index_o,
  output way_t       tag_pkt_way_o,
  output coh_state_e tag_pkt_state_o,
  output ctag_t      tag_pkt_tag_o,
  input  logic       tag_pkt_yumi_i,
  output logic       stat_pkt_v_o,
  output stat_op_e   stat_pkt_op_o,
  output index_t     stat_pkt_index_o,
  input  logic       stat_pkt_yumi_i,
  output logic       data_pkt_v_o,
  output data_op_e   data_pkt_op_o,
  output index_t     data_pkt_index_o,
  output way_t       data_pkt_way_o,
  output beat_t      data_pkt_beat_o,
  output fill_t      data_pkt_data_o,
  input  logic       data_pkt_yumi_i,
  output logic       resp_v_o,
  output resp_type_e resp_type_o,
  output paddr_t     resp_addr_o,
  output lce_id_t    resp_dst_o,
  output lce_id_t    resp_src_o,
  input  logic       resp_ready_and_i,
  output logic       cache_init_done_o,
  output paddr_t     cache_req_addr_o,
  output logic       cache_req_critical_o,
  output logic       cache_req_last_o,
  output logic       cache_req_done_o,
  output logic       credit_return_o
);

  fsm_state_e state_r, state_n;
  paddr_t     addr_r;
  lce_id_t    src_r;
  // tag packet of the current command already taken by the cache
  logic       tag_done_r;
  logic       cmd_hs;
  logic       tag_hs;
  index_t     cmd_index;

  assign cmd_index = cmd_addr_i[`LCE_OFFSET_W +: `LCE_INDEX_W];
  assign cmd_hs    = cmd_v_i & cmd_ready_and_o;
  assign tag_hs    = tag_pkt_v_o & tag_pkt_yumi_i;

  assign cache_init_done_o = (state_r != e_reset) && (state_r != e_clear);

  always_comb begin
    state_n              = state_r;
    cmd_ready_and_o      = 1'b0;
    cnt_inc_o            = 1'b0;
    cnt_clear_o          = 1'b0;
    tag_pkt_v_o          = 1'b0;
    tag_pkt_op_o         = e_tag_set_state;
    tag_pkt_index_o      = cmd_index;
    tag_pkt_way_o        = cmd_way_i;
    tag_pkt_state_o      = e_coh_i;
    tag_pkt_tag_o        = '0;
    stat_pkt_v_o         = 1'b0;
    stat_pkt_op_o        = e_stat_set_clear;
    stat_pkt_index_o     = cmd_index;
    data_pkt_v_o         = 1'b0;
    data_pkt_op_o        = e_data_write;
    data_pkt_index_o     = cmd_index;
    data_pkt_way_o       = cmd_way_i;
    data_pkt_beat_o      = beat_idx_i;
    data_pkt_data_o      = cmd_data_i;
    resp_v_o             = 1'b0;
    resp_type_o          = e_resp_sync_ack;
    resp_addr_o          = cmd_addr_i;
    resp_dst_o           = cmd_src_i;
    resp_src_o           = lce_id_i;
    cache_req_addr_o     = cmd_addr_i;
    cache_req_critical_o = 1'b0;
    cache_req_last_o     = 1'b0;
    cache_req_done_o     = 1'b0;
    credit_return_o      = 1'b0;

    case (state_r)
      e_reset: begin
        state_n = e_clear;
      end

      // sweep every set to invalid, counter is the set index
      e_clear: begin
        tag_pkt_v_o      = 1'b1;
        tag_pkt_op_o     = e_tag_set_clear;
        tag_pkt_index_o  = index_t'(cnt_i);
        stat_pkt_v_o     = 1'b1;
        stat_pkt_index_o = index_t'(cnt_i);
        if (tag_pkt_yumi_i && stat_pkt_yumi_i) begin
          if (cnt_i == cnt_t'(`LCE_SETS-1)) begin
            cnt_clear_o = 1'b1;
            state_n     = e_ready;
          end else begin
            cnt_inc_o = 1'b1;
          end
        end
      end

      e_ready: begin
        case (cmd_type_i)
          e_cmd_sync: begin
            // ack goes out with the command, command leaves with the ack
            resp_v_o        = cmd_v_i;
            cmd_ready_and_o = resp_ready_and_i;
            if (cmd_v_i && resp_ready_and_i) begin
              if (cnt_i == cnt_t'(`LCE_NUM_CCE-1)) begin
                cnt_clear_o = 1'b1;
              end else begin
                cnt_inc_o = 1'b1;
              end
            end
          end

          e_cmd_set_clear: begin
            tag_pkt_v_o     = cmd_v_i & ~backoff_i;
            tag_pkt_op_o    = e_tag_set_clear;
            stat_pkt_v_o    = cmd_v_i & ~backoff_i;
            cmd_ready_and_o = tag_pkt_v_o & tag_pkt_yumi_i & stat_pkt_yumi_i;
          end

          e_cmd_inv: begin
            tag_pkt_v_o     = cmd_v_i & ~tag_done_r;
            // ack held up after the tag write until the CCE takes it
            resp_v_o        = (tag_pkt_v_o & tag_pkt_yumi_i) | tag_done_r;
            resp_type_o     = e_resp_inv_ack;
            cmd_ready_and_o = resp_v_o & resp_ready_and_i;
          end

          e_cmd_st, e_cmd_st_wakeup: begin
            tag_pkt_v_o     = cmd_v_i;
            tag_pkt_state_o = cmd_state_i;
            cmd_ready_and_o = tag_pkt_v_o & tag_pkt_yumi_i;
            if (cmd_type_i == e_cmd_st_wakeup) begin
              cache_req_critical_o = cmd_v_i;
              if (cmd_ready_and_o) begin
                state_n = e_coh_ack;
              end
            end
          end

          e_cmd_data: begin
            // tag write goes first, beats follow once it is taken
            tag_pkt_v_o     = cmd_v_i & first_i & ~tag_done_r;
            tag_pkt_op_o    = e_tag_set_tag;
            tag_pkt_state_o = cmd_state_i;
            tag_pkt_tag_o   = cmd_addr_i[`LCE_OFFSET_W + `LCE_INDEX_W +: `LCE_CTAG_W];
            data_pkt_v_o    = cmd_v_i & (~first_i | tag_done_r);
            cmd_ready_and_o = data_pkt_v_o & data_pkt_yumi_i;
            cache_req_critical_o = cmd_v_i & first_i;
            if (cmd_ready_and_o && last_i) begin
              state_n = e_coh_ack;
            end
          end

          e_cmd_uc_data: begin
            data_pkt_v_o         = cmd_v_i;
            data_pkt_op_o        = e_data_uncached;
            cmd_ready_and_o      = data_pkt_v_o & data_pkt_yumi_i;
            cache_req_critical_o = cmd_v_i;
            cache_req_last_o     = cmd_ready_and_o;
            cache_req_done_o     = cmd_ready_and_o;
            credit_return_o      = cmd_ready_and_o;
          end

          // uncached stores do not block the cache, only the credit returns
          e_cmd_uc_st_done: begin
            cmd_ready_and_o = cmd_v_i;
            credit_return_o = cmd_v_i;
          end

          default: begin
            cmd_ready_and_o = cmd_v_i;
          end
        endcase
      end

      e_coh_ack: begin
        resp_v_o         = 1'b1;
        resp_type_o      = e_resp_coh_ack;
        resp_addr_o      = addr_r;
        resp_dst_o       = src_r;
        cache_req_addr_o = addr_r;
        cache_req_last_o = resp_ready_and_i;
        cache_req_done_o = resp_ready_and_i;
        credit_return_o  = resp_ready_and_i;
        if (resp_ready_and_i) begin
          state_n = e_ready;
        end
      end

      default: begin
        state_n = e_reset;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r    <= e_reset;
      tag_done_r <= 1'b0;
    end else begin
      state_r <= state_n;
      if (cmd_hs) begin
        tag_done_r <= 1'b0;
      end else if ((state_r == e_ready) && tag_hs) begin
        tag_done_r <= 1'b1;
      end
    end
  end

  // header kept for the coh ack sent after the command is gone
  always_ff @(posedge clk_i) begin
    if (cmd_hs) begin
      addr_r <= cmd_addr_i;
      src_r  <= cmd_src_i;
    end
  end

  resp_held_a: assert property (@(posedge clk_i) disable iff (reset_i)
    (resp_v_o && !resp_ready_and_i) |=> resp_v_o);

endmodule

`default_nettype wire

// ==== rtl/lce_pkg.sv ====
`default_nettype none

`include "lce_cfg.svh"

package lce_pkg;

  typedef logic [`LCE_PADDR_W-1:0]         paddr_t;
  typedef logic [`LCE_INDEX_W-1:0]         index_t;
  typedef logic [$clog2(`LCE_ASSOC)-1:0]   way_t;
  typedef logic [`LCE_CTAG_W-1:0]          ctag_t;
  typedef logic [`LCE_FILL_W-1:0]          fill_t;
  typedef logic [$clog2(`LCE_BEATS)-1:0]   beat_t;
  typedef logic [`LCE_ID_W-1:0]            lce_id_t;
  typedef logic [`LCE_CNT_W-1:0]           cnt_t;

  // MOESIF line states
  typedef enum logic [2:0] {
    e_coh_i, e_coh_s, e_coh_e, e_coh_m, e_coh_o, e_coh_f
  } coh_state_e;

  typedef enum logic [3:0] {
    e_cmd_sync,
    e_cmd_set_clear,
    e_cmd_inv,
    e_cmd_st,
    e_cmd_st_wakeup,
    e_cmd_data,
    e_cmd_uc_data,
    e_cmd_uc_st_done
  } cmd_type_e;

  typedef enum logic [1:0] {
    e_resp_sync_ack, e_resp_inv_ack, e_resp_coh_ack
  } resp_type_e;

  // cache memory packet opcodes
  typedef enum logic [1:0] {
    e_tag_set_clear, e_tag_set_state, e_tag_set_tag
  } tag_op_e;

  typedef enum logic [0:0] {
    e_stat_set_clear
  } stat_op_e;

  typedef enum logic [0:0] {
    e_data_write, e_data_uncached
  } data_op_e;

  typedef enum logic [2:0] {
    e_reset, e_clear, e_ready, e_coh_ack
  } fsm_state_e;

endpackage

`default_nettype wire

// ==== rtl/lce_sync_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lce_cfg.svh"

module lce_sync_counter
  import lce_pkg::*;
(
  input  logic clk_i,
  input  logic reset_i,
  input  logic cnt_inc_i,
  input  logic cnt_clear_i,
  output cnt_t cnt_o,
  output logic sync_done_o
);

  cnt_t cnt_r;
  logic sync_done_r;

  assign cnt_o       = cnt_r;
  assign sync_done_o = sync_done_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_r       <= '0;
      sync_done_r <= 1'b0;
    end else begin
      if (cnt_clear_i) begin
        cnt_r <= '0;
      end else if (cnt_inc_i) begin
        cnt_r <= cnt_r + 1'b1;
      end
      // the last sync ack wraps the count at NUM_CCE-1,
      // the init sweep wraps at SETS-1 and leaves this alone
      if (cnt_clear_i && (cnt_r == cnt_t'(`LCE_NUM_CCE-1))) begin
        sync_done_r <= 1'b1;
      end
    end
  end

  // FSM never asks for both in one cycle
  inc_clear_excl_a: assert property (@(posedge clk_i) disable iff (reset_i)
    !(cnt_inc_i && cnt_clear_i));

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+rtl
rtl/lce_pkg.sv
rtl/lce_beat_tracker.sv
rtl/lce_sync_counter.sv
rtl/lce_cmd_fsm.sv
rtl/lce_cmd.sv
tb/tb_lce_cmd.sv

// ==== tb/tb_lce_cmd.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lce_cfg.svh"

module tb_lce_cmd
  import lce_pkg::*;
;

  localparam lce_id_t LCE_ID   = 4'h5;
  // init sweep counts one command per set, plus the directed commands
  localparam int      NUM_CMDS = `LCE_SETS + 10;

  typedef struct packed {
    tag_op_e    op;
    index_t     idx;
    way_t       way;
    coh_state_e st;
    ctag_t      tag;
  } tag_exp_t;

  typedef struct packed {
    stat_op_e op;
    index_t   idx;
  } stat_exp_t;

  typedef struct packed {
    data_op_e op;
    index_t   idx;
    way_t     way;
    beat_t    beat;
    fill_t    data;
  } data_exp_t;

  typedef struct packed {
    resp_type_e typ;
    paddr_t     addr;
    lce_id_t    dst;
    lce_id_t    src;
  } resp_exp_t;

  logic       clk_i;
  logic       reset_i;
  lce_id_t    lce_id_i;
  logic       backoff_i;
  logic       cmd_v_i;
  cmd_type_e  cmd_type_i;
  paddr_t     cmd_addr_i;
  lce_id_t    cmd_src_i;
  way_t       cmd_way_i;
  coh_state_e cmd_state_i;
  fill_t      cmd_data_i;
  logic       cmd_ready_and_o;
  logic       tag_pkt_v_o;
  tag_op_e    tag_pkt_op_o;
  index_t     tag_pkt_index_o;
  way_t       tag_pkt_way_o;
  coh_state_e tag_pkt_state_o;
  ctag_t      tag_pkt_tag_o;
  logic       tag_pkt_yumi_i;
  logic       stat_pkt_v_o;
  stat_op_e   stat_pkt_op_o;
  index_t     stat_pkt_index_o;
  logic       stat_pkt_yumi_i;
  logic       data_pkt_v_o;
  data_op_e   data_pkt_op_o;
  index_t     data_pkt_index_o;
  way_t       data_pkt_way_o;
  beat_t      data_pkt_beat_o;
  fill_t      data_pkt_data_o;
  logic       data_pkt_yumi_i;
  logic       resp_v_o;
  resp_type_e resp_type_o;
  paddr_t     resp_addr_o;
  lce_id_t    resp_dst_o;
  lce_id_t    resp_src_o;
  logic       resp_ready_and_i;
  logic       cache_init_done_o;
  logic       sync_done_o;
  paddr_t     cache_req_addr_o;
  logic       cache_req_critical_o;
  logic       cache_req_last_o;
  logic       cache_req_done_o;
  logic       credit_return_o;

  tag_exp_t  tag_q[$];
  stat_exp_t stat_q[$];
  data_exp_t data_q[$];
  resp_exp_t resp_q[$];

  int     errors;
  int     tests_run;
  int     tests_failed;
  int     test_err_start;
  int     done_cnt;
  int     credit_cnt;
  int     exp_done;
  int     exp_credit;
  paddr_t req_addr_exp;
  logic   init_seen;
  string  test_name;

  lce_cmd u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // random cache and CCE back-pressure
  // tag and stat memories answer together
  initial begin
    void'($urandom(95331));
    forever begin
      @(negedge clk_i);
      tag_pkt_yumi_i   = ($urandom % 4) != 0;
      stat_pkt_yumi_i  = tag_pkt_yumi_i;
      data_pkt_yumi_i  = ($urandom % 4) != 0;
      resp_ready_and_i = ($urandom % 3) != 0;
    end
  end

  initial begin
    #((NUM_CMDS * 200 + 10) * 10);
    $display("timeout: the DUT stopped making progress in test %s", test_name);
    $display("*** FAILED ***");
    $finish;
  end

  function automatic fill_t beat_data(input paddr_t a, input beat_t b);
    return {a, 28'h5a5a5a5, 2'b00, b};
  endfunction

  // expected cache packets and response of one command
  function automatic void predict(input cmd_type_e t, input paddr_t a, input lce_id_t s,
                                  input way_t w, input coh_state_e st);
    index_t idx;
    ctag_t  ctag;
    idx  = a[`LCE_OFFSET_W +: `LCE_INDEX_W];
    ctag = a[`LCE_OFFSET_W + `LCE_INDEX_W +: `LCE_CTAG_W];
    case (t)
      e_cmd_sync: begin
        resp_q.push_back('{e_resp_sync_ack, a, s, LCE_ID});
      end
      e_cmd_set_clear: begin
        tag_q.push_back('{e_tag_set_clear, idx, w, e_coh_i, '0});
        stat_q.push_back('{e_stat_set_clear, idx});
      end
      e_cmd_inv: begin
        tag_q.push_back('{e_tag_set_state, idx, w, e_coh_i, '0});
        resp_q.push_back('{e_resp_inv_ack, a, s, LCE_ID});
      end
      e_cmd_st: begin
        tag_q.push_back('{e_tag_set_state, idx, w, st, '0});
      end
      e_cmd_st_wakeup: begin
        tag_q.push_back('{e_tag_set_state, idx, w, st, '0});
        resp_q.push_back('{e_resp_coh_ack, a, s, LCE_ID});
        req_addr_exp = a;
        exp_done++;
        exp_credit++;
      end
      e_cmd_data: begin
        tag_q.push_back('{e_tag_set_tag, idx, w, st, ctag});
        for (int b = 0; b < `LCE_BEATS; b++) begin
          data_q.push_back('{e_data_write, idx, w, beat_t'(b), beat_data(a, beat_t'(b))});
        end
        resp_q.push_back('{e_resp_coh_ack, a, s, LCE_ID});
        req_addr_exp = a;
        exp_done++;
        exp_credit++;
      end
      e_cmd_uc_data: begin
        data_q.push_back('{e_data_uncached, idx, w, '0, beat_data(a, '0)});
        req_addr_exp = a;
        exp_done++;
        exp_credit++;
      end
      default: begin
        exp_credit++;
      end
    endcase
  endfunction

  task automatic check_tag(input tag_op_e op, input index_t idx, input way_t way,
                           input coh_state_e st, input ctag_t tag);
    tag_exp_t e;
    logic     bad;
    if (tag_q.size() == 0) begin
      $display("error at %0t: tag packet %s taken when none was expected", $time, op.name());
      errors++;
    end else begin
      e   = tag_q.pop_front();
      bad = (op != e.op) || (idx != e.idx) || (st != e.st);
      if ((e.op != e_tag_set_clear) && (way != e.way)) bad = 1'b1;
      if ((e.op == e_tag_set_tag) && (tag != e.tag)) bad = 1'b1;
      if (bad) begin
        $display("Mismatch at %0t: tag got %s idx %0d way %0d %s tag %h, exp %s %0d %0d %s %h",
                 $time, op.name(), idx, way, st.name(), tag,
                 e.op.name(), e.idx, e.way, e.st.name(), e.tag);
        errors++;
      end
    end
  endtask

  task automatic check_stat(input stat_op_e op, input index_t idx);
    stat_exp_t e;
    if (stat_q.size() == 0) begin
      $display("error at %0t: stat packet taken when none was expected", $time);
      errors++;
    end else begin
      e = stat_q.pop_front();
      if ((op != e.op) || (idx != e.idx)) begin
        $display("Mismatch at %0t: stat got idx %0d, expected idx %0d", $time, idx, e.idx);
        errors++;
      end
    end
  endtask

  task automatic check_data(input data_op_e op, input index_t idx, input way_t way,
                            input beat_t beat, input fill_t data);
    data_exp_t e;
    if (data_q.size() == 0) begin
      $display("error at %0t: data packet taken when none was expected", $time);
      errors++;
    end else begin
      e = data_q.pop_front();
      if ((op != e.op) || (idx != e.idx) || (way != e.way) || (beat != e.beat) ||
          (data != e.data)) begin
        $display("Mismatch at %0t: data got %s idx %0d way %0d beat %0d %h, exp %s %0d %0d %0d %h",
                 $time, op.name(), idx, way, beat, data,
                 e.op.name(), e.idx, e.way, e.beat, e.data);
        errors++;
      end
    end
  endtask

  task automatic check_resp(input resp_type_e typ, input paddr_t addr, input lce_id_t dst,
                            input lce_id_t src);
    resp_exp_t e;
    logic      bad;
    if (resp_q.size() == 0) begin
      $display("error at %0t: response %s sent when none was expected", $time, typ.name());
      errors++;
    end else begin
      e   = resp_q.pop_front();
      bad = (typ != e.typ) || (dst != e.dst) || (src != e.src);
      // a sync ack carries no meaningful address
      if ((e.typ != e_resp_sync_ack) && (addr != e.addr)) bad = 1'b1;
      if (bad) begin
        $display("Mismatch at %0t: resp got %s addr %h dst %0d src %0d, exp %s %h %0d %0d",
                 $time, typ.name(), addr, dst, src, e.typ.name(), e.addr, e.dst, e.src);
        errors++;
      end
    end
  endtask

  // compares every handshake one ns before the rising edge
  always begin : handshake_monitor
    logic done_exp;
    logic credit_exp;
    @(negedge clk_i);
    #4;
    if (!reset_i) begin
      if (tag_pkt_v_o && tag_pkt_yumi_i) begin
        check_tag(tag_pkt_op_o, tag_pkt_index_o, tag_pkt_way_o, tag_pkt_state_o, tag_pkt_tag_o);
      end
      if (stat_pkt_v_o && stat_pkt_yumi_i) begin
        check_stat(stat_pkt_op_o, stat_pkt_index_o);
      end
      if (data_pkt_v_o && data_pkt_yumi_i) begin
        check_data(data_pkt_op_o, data_pkt_index_o, data_pkt_way_o, data_pkt_beat_o,
                   data_pkt_data_o);
        if ((data_pkt_op_o == e_data_write) &&
            (cache_req_critical_o != (data_pkt_beat_o == '0))) begin
          $display("Mismatch at %0t: critical %0b on beat %0d", $time,
                   cache_req_critical_o, data_pkt_beat_o);
          errors++;
        end
      end
      if (resp_v_o && resp_ready_and_i) begin
        check_resp(resp_type_o, resp_addr_o, resp_dst_o, resp_src_o);
      end
      done_exp   = (resp_v_o && resp_ready_and_i && (resp_type_o == e_resp_coh_ack)) ||
                   (data_pkt_v_o && data_pkt_yumi_i && (data_pkt_op_o == e_data_uncached));
      credit_exp = done_exp ||
                   (cmd_v_i && cmd_ready_and_o && (cmd_type_i == e_cmd_uc_st_done));
      if (cache_req_done_o != done_exp) begin
        $display("Mismatch at %0t: done %0b, expected %0b", $time, cache_req_done_o, done_exp);
        errors++;
      end
      if (cache_req_last_o != done_exp) begin
        $display("Mismatch at %0t: last %0b, expected %0b", $time, cache_req_last_o, done_exp);
        errors++;
      end
      if (done_exp && (cache_req_addr_o != req_addr_exp)) begin
        $display("Mismatch at %0t: request address %h, expected %h", $time,
                 cache_req_addr_o, req_addr_exp);
        errors++;
      end
      if (credit_return_o != credit_exp) begin
        $display("Mismatch at %0t: credit %0b, expected %0b", $time, credit_return_o,
                 credit_exp);
        errors++;
      end
      if (cache_req_done_o) done_cnt++;
      if (credit_return_o) credit_cnt++;
      if (cache_init_done_o) begin
        init_seen = 1'b1;
      end else if (init_seen) begin
        $display("Mismatch at %0t: cache init done dropped after rising", $time);
        errors++;
      end
    end
  end

  task automatic start_test(input string name);
    test_name      = name;
    test_err_start = errors;
    done_cnt       = 0;
    credit_cnt     = 0;
    exp_done       = 0;
    exp_credit     = 0;
  endtask

  // waits for every expected packet, then watches a few idle cycles
  task automatic end_test();
    while ((tag_q.size() + stat_q.size() + data_q.size() + resp_q.size()) != 0) begin
      @(negedge clk_i);
    end
    repeat (4) @(negedge clk_i);
    if ((done_cnt != exp_done) || (credit_cnt != exp_credit)) begin
      $display("Mismatch at %0t: %0d done and %0d credit pulses, expected %0d and %0d",
               $time, done_cnt, credit_cnt, exp_done, exp_credit);
      errors++;
    end
    tests_run++;
    if (errors == test_err_start) begin
      $display("test %-12s ok", test_name);
    end else begin
      tests_failed++;
      $display("test %-12s %0d errors", test_name, errors - test_err_start);
    end
  endtask

  task automatic drive_fields(input cmd_type_e t, input paddr_t a, input lce_id_t s,
                              input way_t w, input coh_state_e st, input fill_t d);
    cmd_v_i     = 1'b1;
    cmd_type_i  = t;
    cmd_addr_i  = a;
    cmd_src_i   = s;
    cmd_way_i   = w;
    cmd_state_i = st;
    cmd_data_i  = d;
  endtask

  // called on a falling edge, returns on the falling edge after the last beat
  task automatic send_cmd(input cmd_type_e t, input paddr_t a, input lce_id_t s,
                          input way_t w, input coh_state_e st);
    int   beats;
    int   b;
    logic accepted;
    beats = (t == e_cmd_data) ? `LCE_BEATS : 1;
    predict(t, a, s, w, st);
    for (b = 0; b < beats; b++) begin
      drive_fields(t, a, s, w, st, beat_data(a, beat_t'(b)));
      accepted = 1'b0;
      while (!accepted) begin
        #4;
        accepted = cmd_ready_and_o;
        @(negedge clk_i);
      end
    end
    cmd_v_i = 1'b0;
  endtask

  task automatic test_init();
    start_test("init");
    for (int i = 0; i < `LCE_SETS; i++) begin
      tag_q.push_back('{e_tag_set_clear, index_t'(i), '0, e_coh_i, '0});
      stat_q.push_back('{e_stat_set_clear, index_t'(i)});
    end
    while ((tag_q.size() + stat_q.size()) != 0) begin
      #3;
      if (cache_init_done_o) begin
        $display("Mismatch at %0t: cache init done high during the sweep", $time);
        errors++;
      end
      @(negedge clk_i);
    end
    #3;
    if (!cache_init_done_o) begin
      $display("Mismatch at %0t: cache init done low after the sweep", $time);
      errors++;
    end
    @(negedge clk_i);
    end_test();
  endtask

  task automatic test_sync();
    start_test("sync");
    for (int i = 0; i < `LCE_NUM_CCE; i++) begin
      #3;
      if (sync_done_o) begin
        $display("Mismatch at %0t: sync done high before ack %0d", $time, i);
        errors++;
      end
      @(negedge clk_i);
      send_cmd(e_cmd_sync, 32'h0, lce_id_t'(i + 1), '0, e_coh_i);
    end
    #3;
    if (!sync_done_o) begin
      $display("Mismatch at %0t: sync done low after the last ack", $time);
      errors++;
    end
    @(negedge clk_i);
    end_test();
  endtask

  task automatic test_set_clear();
    start_test("set_clear");
    backoff_i = 1'b1;
    drive_fields(e_cmd_set_clear, 32'h0000_0060, 4'h3, '0, e_coh_i, '0);
    repeat (5) begin
      #3;
      if (tag_pkt_v_o || stat_pkt_v_o || cmd_ready_and_o) begin
        $display("error at %0t: set clear issued packets while backoff was high", $time);
        errors++;
      end
      @(negedge clk_i);
    end
    backoff_i = 1'b0;
    send_cmd(e_cmd_set_clear, 32'h0000_0060, 4'h3, '0, e_coh_i);
    end_test();
  endtask

  task automatic run_one(input string name, input cmd_type_e t, input paddr_t a,
                         input way_t w, input coh_state_e st);
    start_test(name);
    send_cmd(t, a, 4'h3, w, st);
    end_test();
  endtask

  initial begin
    errors           = 0;
    tests_run        = 0;
    tests_failed     = 0;
    req_addr_exp     = '0;
    init_seen        = 1'b0;
    test_name        = "reset";
    reset_i          = 1'b1;
    lce_id_i         = LCE_ID;
    backoff_i        = 1'b0;
    cmd_v_i          = 1'b0;
    cmd_type_i       = e_cmd_sync;
    cmd_addr_i       = '0;
    cmd_src_i        = '0;
    cmd_way_i        = '0;
    cmd_state_i      = e_coh_i;
    cmd_data_i       = '0;
    tag_pkt_yumi_i   = 1'b0;
    stat_pkt_yumi_i  = 1'b0;
    data_pkt_yumi_i  = 1'b0;
    resp_ready_and_i = 1'b0;
    repeat (10) @(negedge clk_i);
    reset_i = 1'b0;

    test_init();
    test_sync();
    test_set_clear();
    run_one("inv", e_cmd_inv, 32'h1234_56a0, 1'b1, e_coh_i);
    run_one("data", e_cmd_data, 32'hcafe_01e0, 1'b0, e_coh_e);
    run_one("st_wakeup", e_cmd_st_wakeup, 32'h0bad_f020, 1'b1, e_coh_s);
    run_one("st", e_cmd_st, 32'h7777_7740, 1'b0, e_coh_m);
    run_one("uc_data", e_cmd_uc_data, 32'h4000_0080, 1'b1, e_coh_i);
    run_one("uc_st_done", e_cmd_uc_st_done, 32'h0000_0000, 1'b0, e_coh_i);

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
